/* build.f */
source/rv_pkg.sv
source/exmem_if.sv
source/fetch_unit.sv
source/decoder.sv
source/reg_file.sv
source/alu_exec.sv
source/data_mem.sv
source/hazard_unit.sv
source/rv32_core.sv
tests/tb_core.sv

/* run.sh */
#!/bin/sh
# compile and run tb_core with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_core -f build.f -o tb_core_sim \
   && ./obj_dir/tb_core_sim > sim.log 2>&1 \
   ; cat sim.log 2>/dev/null \
   ; test -f sim.log \
   && ! grep -q "FAIL: see errors above" sim.log \
   && grep -q "PASS: all tests" sim.log \
   || { echo "simulation failed"; exit 1; }

/* tests/tb_core.sv */
`timescale 1ns/1ps

module tb_core;

   localparam int xlen    = rv_pkg::xlen;
   localparam int aw      = $clog2(rv_pkg::imem_words);
   localparam int ntests  = 5;
   localparam int maxw    = 16;

   localparam logic [6:0] opc_imm  = 7'b0010011;
   localparam logic [6:0] opc_load = 7'b0000011;
   localparam logic [6:0] opc_jalr = 7'b1100111;

   logic            clk;
   logic            reset;
   logic            imem_we_i;
   logic [aw-1:0]   imem_addr_i;
   logic [xlen-1:0] imem_data_i;
   logic            wb_valid_o;
   logic [4:0]      wb_rd_o;
   logic [xlen-1:0] wb_data_o;
   logic [xlen-1:0] pc_o;

   logic [31:0]     prog [ntests][maxw];
   logic [4:0]      exp_rd [ntests][maxw];
   logic [xlen-1:0] exp_data [ntests][maxw];
   int              nwords [ntests];
   int              nexp [ntests];
   string           names [ntests];
   logic [31:0]     lcg_state = 32'h120d41e1;
   int              errors = 0;
   int              passed = 0;
   int              failed = 0;
   logic            table_ready = 1'b0;

   rv32_core dut_i (
      .clk         (clk),
      .reset       (reset),
      .imem_we_i   (imem_we_i),
      .imem_addr_i (imem_addr_i),
      .imem_data_i (imem_data_i),
      .wb_valid_o  (wb_valid_o),
      .wb_rd_o     (wb_rd_o),
      .wb_data_o   (wb_data_o),
      .pc_o        (pc_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // instruction assemblers, straight from the RV32I encodings
   function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] lui_insn(input logic [19:0] imm, input logic [4:0] rd);
      return {imm, rd, 7'b0110111};
   endfunction

   function automatic logic [31:0] jal_insn(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   task automatic add_word(input int t, input logic [31:0] w);
      prog[t][nwords[t]] = w;
      nwords[t]++;
   endtask

   task automatic add_expect(input int t, input logic [4:0] rd, input logic [xlen-1:0] d);
      exp_rd[t][nexp[t]]   = rd;
      exp_data[t][nexp[t]] = d;
      nexp[t]++;
   endtask

   task automatic build_tests();
      logic [11:0]     ia;
      logic [11:0]     ib;
      logic [xlen-1:0] a;
      logic [xlen-1:0] b;
      logic [31:0]     r;
      for (int t = 0; t < ntests; t++) begin
         nwords[t] = 0;
         nexp[t]   = 0;
         for (int i = 0; i < maxw; i++) begin
            prog[t][i] = '0;
         end
      end
      // test 1: random immediates, chained through forwarding
      names[0] = "random add/sub";
      r  = lcg_next();
      ia = r[31:20];
      r  = lcg_next();
      ib = r[31:20];
      a  = {{20{ia[11]}}, ia};
      b  = {{20{ib[11]}}, ib};
      add_word(0, i_type(ia, 5'd0, 3'b000, 5'd1, opc_imm));
      add_word(0, i_type(ib, 5'd0, 3'b000, 5'd2, opc_imm));
      add_word(0, r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
      add_word(0, r_type(7'h00, 5'd1, 5'd3, 3'b000, 5'd4));
      add_word(0, r_type(7'h20, 5'd2, 5'd4, 3'b000, 5'd5));
      add_word(0, jal_insn(21'd0, 5'd0));
      add_expect(0, 5'd1, a);
      add_expect(0, 5'd2, b);
      add_expect(0, 5'd3, a + b);
      add_expect(0, 5'd4, a + b + a);
      add_expect(0, 5'd5, a + b + a - b);
      // test 2: every ALU operation on fixed values
      names[1] = "alu ops";
      add_word(1, i_type(12'd5, 5'd0, 3'b000, 5'd1, opc_imm));
      add_word(1, i_type(12'hffd, 5'd0, 3'b000, 5'd2, opc_imm));
      add_word(1, lui_insn(20'h12345, 5'd3));
      add_word(1, r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd4));
      add_word(1, r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd5));
      add_word(1, r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd6));
      add_word(1, r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd7));
      add_word(1, r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd8));
      add_word(1, r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd9));
      add_word(1, r_type(7'h00, 5'd1, 5'd1, 3'b001, 5'd10));
      add_word(1, r_type(7'h00, 5'd1, 5'd2, 3'b101, 5'd11));
      add_word(1, i_type(12'd0, 5'd2, 3'b010, 5'd12, opc_imm));
      add_word(1, i_type(12'h0f0, 5'd1, 3'b100, 5'd13, opc_imm));
      add_word(1, i_type(12'h100, 5'd1, 3'b110, 5'd14, opc_imm));
      add_word(1, i_type(12'h0ff, 5'd2, 3'b111, 5'd15, opc_imm));
      add_word(1, jal_insn(21'd0, 5'd0));
      add_expect(1, 5'd1, 32'h0000_0005);
      add_expect(1, 5'd2, 32'hffff_fffd);
      add_expect(1, 5'd3, 32'h1234_5000);
      add_expect(1, 5'd4, 32'h0000_0002);
      add_expect(1, 5'd5, 32'h0000_0008);
      add_expect(1, 5'd6, 32'h0000_0005);
      add_expect(1, 5'd7, 32'hffff_fffd);
      add_expect(1, 5'd8, 32'hffff_fff8);
      add_expect(1, 5'd9, 32'h0000_0001);
      add_expect(1, 5'd10, 32'h0000_00a0);
      add_expect(1, 5'd11, 32'h07ff_ffff);
      add_expect(1, 5'd12, 32'h0000_0001);
      add_expect(1, 5'd13, 32'h0000_00f5);
      add_expect(1, 5'd14, 32'h0000_0105);
      add_expect(1, 5'd15, 32'h0000_00fd);
      // test 3: store then load, load-use pairs need the stall
      names[2] = "load/store";
      add_word(2, i_type(12'h040, 5'd0, 3'b000, 5'd1, opc_imm));
      add_word(2, i_type(12'd123, 5'd0, 3'b000, 5'd2, opc_imm));
      add_word(2, s_type(12'd4, 5'd2, 5'd1));
      add_word(2, i_type(12'd4, 5'd1, 3'b010, 5'd3, opc_load));
      add_word(2, r_type(7'h00, 5'd2, 5'd3, 3'b000, 5'd4));
      add_word(2, s_type(12'd8, 5'd4, 5'd1));
      add_word(2, i_type(12'd8, 5'd1, 3'b010, 5'd5, opc_load));
      add_word(2, r_type(7'h00, 5'd5, 5'd5, 3'b000, 5'd6));
      add_word(2, jal_insn(21'd0, 5'd0));
      add_expect(2, 5'd1, 32'd64);
      add_expect(2, 5'd2, 32'd123);
      add_expect(2, 5'd3, 32'd123);
      add_expect(2, 5'd4, 32'd246);
      add_expect(2, 5'd5, 32'd246);
      add_expect(2, 5'd6, 32'd492);
      // test 4: taken beq, not-taken bne, taken blt and bne
      names[3] = "branches";
      add_word(3, i_type(12'd1, 5'd0, 3'b000, 5'd1, opc_imm));
      add_word(3, i_type(12'd1, 5'd0, 3'b000, 5'd2, opc_imm));
      add_word(3, b_type(13'd12, 5'd2, 5'd1, 3'b000));
      add_word(3, i_type(12'd7, 5'd0, 3'b000, 5'd3, opc_imm));
      add_word(3, i_type(12'd8, 5'd0, 3'b000, 5'd4, opc_imm));
      add_word(3, b_type(13'd12, 5'd2, 5'd1, 3'b001));
      add_word(3, i_type(12'd9, 5'd0, 3'b000, 5'd5, opc_imm));
      add_word(3, b_type(13'd12, 5'd1, 5'd0, 3'b100));
      add_word(3, i_type(12'd10, 5'd0, 3'b000, 5'd6, opc_imm));
      add_word(3, i_type(12'd11, 5'd0, 3'b000, 5'd7, opc_imm));
      add_word(3, b_type(13'd12, 5'd0, 5'd2, 3'b001));
      add_word(3, i_type(12'd12, 5'd0, 3'b000, 5'd8, opc_imm));
      add_word(3, i_type(12'd13, 5'd0, 3'b000, 5'd9, opc_imm));
      add_word(3, i_type(12'd14, 5'd0, 3'b000, 5'd10, opc_imm));
      add_word(3, jal_insn(21'd0, 5'd0));
      add_expect(3, 5'd1, 32'd1);
      add_expect(3, 5'd2, 32'd1);
      add_expect(3, 5'd5, 32'd9);
      add_expect(3, 5'd10, 32'd14);
      // test 5: jal and jalr links, x0 as a target and a source
      names[4] = "jumps and x0";
      add_word(4, jal_insn(21'd12, 5'd1));
      add_word(4, i_type(12'd1, 5'd0, 3'b000, 5'd2, opc_imm));
      add_word(4, i_type(12'd2, 5'd0, 3'b000, 5'd3, opc_imm));
      add_word(4, i_type(12'd28, 5'd0, 3'b000, 5'd4, opc_imm));
      add_word(4, i_type(12'd0, 5'd4, 3'b000, 5'd5, opc_jalr));
      add_word(4, i_type(12'd3, 5'd0, 3'b000, 5'd6, opc_imm));
      add_word(4, i_type(12'd4, 5'd0, 3'b000, 5'd7, opc_imm));
      add_word(4, i_type(12'd99, 5'd0, 3'b000, 5'd0, opc_imm));
      add_word(4, r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd8));
      add_word(4, jal_insn(21'd0, 5'd0));
      add_expect(4, 5'd1, 32'd4);
      add_expect(4, 5'd4, 32'd28);
      add_expect(4, 5'd5, 32'd20);
      add_expect(4, 5'd8, 32'd4);
   endtask

   task automatic check_rd(input int t, input int n, input logic [4:0] act,
                           input logic [4:0] exp);
      if (act !== exp) begin
         $display("FAILED at %0t: test %0d write %0d went to x%0d, expected x%0d",
                  $time, t + 1, n, act, exp);
         errors++;
      end
   endtask

   task automatic check_data(input int t, input int n, input logic [xlen-1:0] act,
                             input logic [xlen-1:0] exp);
      if (act !== exp) begin
         $display("FAILED at %0t: test %0d write %0d data %h, expected %h",
                  $time, t + 1, n, act, exp);
         errors++;
      end
   endtask

   // the closing jal x0, 0 is refetched along with its two flushed successors
   task automatic check_pc(input int t, input logic [xlen-1:0] act,
                           input logic [xlen-1:0] loop_pc);
      if (act !== loop_pc && act !== loop_pc + 32'd4 && act !== loop_pc + 32'd8) begin
         $display("FAILED at %0t: test %0d pc %h outside the final loop at %h",
                  $time, t + 1, act, loop_pc);
         errors++;
      end
   endtask

   // whole program window is written so older words never run
   task automatic load_program(input int t);
      @(negedge clk);
      reset = 1'b1;
      for (int i = 0; i < maxw; i++) begin
         imem_we_i   = 1'b1;
         imem_addr_i = i[aw-1:0];
         imem_data_i = prog[t][i];
         @(negedge clk);
      end
      imem_we_i = 1'b0;
      @(negedge clk);
      reset = 1'b0;
   endtask

   task automatic run_test(input int t);
      int              got;
      int              cycles;
      int              errs_before;
      logic [xlen-1:0] loop_pc;
      got         = 0;
      cycles      = 0;
      errs_before = errors;
      loop_pc     = 4 * (nwords[t] - 1);
      load_program(t);
      while (got < nexp[t] && cycles < 30 * nwords[t]) begin
         @(negedge clk);
         cycles++;
         if (wb_valid_o === 1'b1) begin
            check_rd(t, got, wb_rd_o, exp_rd[t][got]);
            check_data(t, got, wb_data_o, exp_data[t][got]);
            got++;
         end
      end
      if (got < nexp[t]) begin
         $display("test %0d: only %0d of %0d expected register writes appeared",
                  t + 1, got, nexp[t]);
         errors++;
      end
      // skipped instructions must not retire late
      repeat (8) begin
         @(negedge clk);
         check_pc(t, pc_o, loop_pc);
         if (wb_valid_o === 1'b1) begin
            $display("test %0d: unexpected write to x%0d after the last expected one",
                     t + 1, wb_rd_o);
            errors++;
         end
      end
      if (errors == errs_before) begin
         $display("test %0d (%s): passed, %0d writes", t + 1, names[t], got);
         passed++;
      end else begin
         $display("test %0d (%s): failed, %0d errors", t + 1, names[t], errors - errs_before);
         failed++;
      end
   endtask

   // watchdog, 40 cycles per program word plus load and drain time
   initial begin
      int limit;
      limit = 0;
      wait (table_ready);
      for (int t = 0; t < ntests; t++) begin
         limit += 40 * nwords[t] + 30;
      end
      repeat (limit) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      reset       = 1'b1;
      imem_we_i   = 1'b0;
      imem_addr_i = '0;
      imem_data_i = '0;
      build_tests();
      table_ready = 1'b1;
      for (int t = 0; t < ntests; t++) begin
         run_test(t);
      end
      $display("tests %0d, passed %0d, failed %0d, errors %0d", ntests, passed, failed, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

/* source/rv32_core.sv */
`timescale 1ns/1ps

module rv32_core (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       imem_we_i,
   input  logic [rv_pkg::imem_aw-1:0] imem_addr_i,
   input  logic [rv_pkg::xlen-1:0]    imem_data_i,
   output logic                       wb_valid_o,
   output logic [4:0]                 wb_rd_o,
   output logic [rv_pkg::xlen-1:0]    wb_data_o,
   output logic [rv_pkg::xlen-1:0]    pc_o
);
   import rv_pkg::*;

   logic [xlen-1:0] fetch_pc;
   logic [xlen-1:0] fd_pc;
   logic [xlen-1:0] fd_insn;
   logic            stall;
   logic            redirect;
   logic [xlen-1:0] target;

   logic [4:0]      dec_rs1;
   logic [4:0]      dec_rs2;
   logic [4:0]      dec_rd;
   logic [xlen-1:0] dec_imm;
   op_e             dec_op;
   logic            dec_reg_write;
   logic            dec_mem_read;
   logic            dec_mem_write;
   logic [xlen-1:0] rf_rd1;
   logic [xlen-1:0] rf_rd2;

   id_ex_t          id_ex_q;
   mem_wb_t         mem_wb_q;
   fwd_e            fwd1;
   fwd_e            fwd2;
   logic [xlen-1:0] op1_fwd;
   logic [xlen-1:0] op2_fwd;
   logic [xlen-1:0] load_data;

   exmem_if em_d ();
   exmem_if em_q ();

   fetch_unit fetch_i (
      .clk         (clk),
      .reset       (reset),
      .stall_i     (stall),
      .redirect_i  (redirect),
      .target_i    (target),
      .imem_we_i   (imem_we_i),
      .imem_addr_i (imem_addr_i),
      .imem_data_i (imem_data_i),
      .pc_o        (fetch_pc),
      .insn_o      (fd_insn)
   );

   // pc half of the fetch/decode register
   always_ff @(posedge clk) begin
      if (reset || redirect) begin
         fd_pc <= '0;
      end else if (!stall) begin
         fd_pc <= fetch_pc;
      end
   end

   decoder decoder_i (
      .insn_i      (fd_insn),
      .rs1_o       (dec_rs1),
      .rs2_o       (dec_rs2),
      .rd_o        (dec_rd),
      .imm_o       (dec_imm),
      .op_o        (dec_op),
      .reg_write_o (dec_reg_write),
      .mem_read_o  (dec_mem_read),
      .mem_write_o (dec_mem_write)
   );

   reg_file reg_file_i (
      .clk   (clk),
      .reset (reset),
      .rs1_i (dec_rs1),
      .rs2_i (dec_rs2),
      .rd_i  (mem_wb_q.rd),
      .we_i  (mem_wb_q.reg_write),
      .wd_i  (mem_wb_q.result),
      .rd1_o (rf_rd1),
      .rd2_o (rf_rd2)
   );

   // stall and flush both turn decode/execute into a bubble
   always_ff @(posedge clk) begin
      if (reset || redirect || stall) begin
         id_ex_q <= '0;
      end else begin
         id_ex_q.pc        <= fd_pc;
         id_ex_q.rs1       <= dec_rs1;
         id_ex_q.rs2       <= dec_rs2;
         id_ex_q.rd        <= dec_rd;
         id_ex_q.op1       <= rf_rd1;
         id_ex_q.op2       <= rf_rd2;
         id_ex_q.imm       <= dec_imm;
         id_ex_q.op        <= dec_op;
         id_ex_q.reg_write <= dec_reg_write;
         id_ex_q.mem_read  <= dec_mem_read;
         id_ex_q.mem_write <= dec_mem_write;
      end
   end

   hazard_unit hazard_i (
      .ex_rs1_i      (id_ex_q.rs1),
      .ex_rs2_i      (id_ex_q.rs2),
      .id_rs1_i      (dec_rs1),
      .id_rs2_i      (dec_rs2),
      .ex_mem_read_i (id_ex_q.mem_read),
      .ex_rd_i       (id_ex_q.rd),
      .mem_rd_i      (em_q.rd),
      .mem_write_i   (em_q.reg_write),
      .wb_rd_i       (mem_wb_q.rd),
      .wb_write_i    (mem_wb_q.reg_write),
      .fwd1_o        (fwd1),
      .fwd2_o        (fwd2),
      .stall_o       (stall)
   );

   // operand muxes in front of execute
   always_comb begin
      case (fwd1)
         fwd_mem: op1_fwd = em_q.alu_result;
         fwd_wb:  op1_fwd = mem_wb_q.result;
         default: op1_fwd = id_ex_q.op1;
      endcase
   end

   always_comb begin
      case (fwd2)
         fwd_mem: op2_fwd = em_q.alu_result;
         fwd_wb:  op2_fwd = mem_wb_q.result;
         default: op2_fwd = id_ex_q.op2;
      endcase
   end

   alu_exec alu_i (
      .ex_i       (id_ex_q),
      .op1_i      (op1_fwd),
      .op2_i      (op2_fwd),
      .redirect_o (redirect),
      .target_o   (target),
      .em         (em_d)
   );

   // execute/memory register
   always_ff @(posedge clk) begin
      if (reset) begin
         em_q.alu_result <= '0;
         em_q.store_data <= '0;
         em_q.rd         <= '0;
         em_q.reg_write  <= 1'b0;
         em_q.mem_read   <= 1'b0;
         em_q.mem_write  <= 1'b0;
      end else begin
         em_q.alu_result <= em_d.alu_result;
         em_q.store_data <= em_d.store_data;
         em_q.rd         <= em_d.rd;
         em_q.reg_write  <= em_d.reg_write;
         em_q.mem_read   <= em_d.mem_read;
         em_q.mem_write  <= em_d.mem_write;
      end
   end

   data_mem data_mem_i (
      .clk         (clk),
      .em          (em_q),
      .load_data_o (load_data)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         mem_wb_q <= '0;
      end else begin
         mem_wb_q.rd        <= em_q.rd;
         mem_wb_q.result    <= em_q.mem_read ? load_data : em_q.alu_result;
         mem_wb_q.reg_write <= em_q.reg_write;
      end
   end

   // x0 writes retire silently
   assign wb_valid_o = mem_wb_q.reg_write && (mem_wb_q.rd != 5'd0);
   assign wb_rd_o    = mem_wb_q.rd;
   assign wb_data_o  = mem_wb_q.result;
   assign pc_o       = fetch_pc;

endmodule

/* source/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
   input  logic [4:0]   ex_rs1_i,
   input  logic [4:0]   ex_rs2_i,
   input  logic [4:0]   id_rs1_i,
   input  logic [4:0]   id_rs2_i,
   input  logic         ex_mem_read_i,
   input  logic [4:0]   ex_rd_i,
   input  logic [4:0]   mem_rd_i,
   input  logic         mem_write_i,
   input  logic [4:0]   wb_rd_i,
   input  logic         wb_write_i,
   output rv_pkg::fwd_e fwd1_o,
   output rv_pkg::fwd_e fwd2_o,
   output logic         stall_o
);
   import rv_pkg::*;

   // memory stage holds the younger result so it wins
   always_comb begin
      fwd1_o = fwd_none;
      if (ex_rs1_i != 5'd0 && mem_write_i && mem_rd_i == ex_rs1_i) begin
         fwd1_o = fwd_mem;
      end else if (ex_rs1_i != 5'd0 && wb_write_i && wb_rd_i == ex_rs1_i) begin
         fwd1_o = fwd_wb;
      end
   end

   always_comb begin
      fwd2_o = fwd_none;
      if (ex_rs2_i != 5'd0 && mem_write_i && mem_rd_i == ex_rs2_i) begin
         fwd2_o = fwd_mem;
      end else if (ex_rs2_i != 5'd0 && wb_write_i && wb_rd_i == ex_rs2_i) begin
         fwd2_o = fwd_wb;
      end
   end

   // loaded data only exists from writeback on
   assign stall_o = ex_mem_read_i && ex_rd_i != 5'd0 &&
                    (ex_rd_i == id_rs1_i || ex_rd_i == id_rs2_i);

endmodule

/* source/data_mem.sv */
`timescale 1ns/1ps

module data_mem (
   input  logic                    clk,
   exmem_if.mem_mp                 em,
   output logic [rv_pkg::xlen-1:0] load_data_o
);
   import rv_pkg::*;

   logic [xlen-1:0]    mem [dmem_words];
   logic [dmem_aw-1:0] idx;

   // word index, upper address bits wrap
   assign idx = em.alu_result[dmem_aw+1:2];

   always_ff @(posedge clk) begin
      if (em.mem_write) begin
         mem[idx] <= em.store_data;
      end
   end

   assign load_data_o = em.mem_read ? mem[idx] : '0;

endmodule

/* source/alu_exec.sv */
`timescale 1ns/1ps

module alu_exec (
   input  rv_pkg::id_ex_t          ex_i,
   input  logic [rv_pkg::xlen-1:0] op1_i,
   input  logic [rv_pkg::xlen-1:0] op2_i,
   output logic                    redirect_o,
   output logic [rv_pkg::xlen-1:0] target_o,
   exmem_if.exec_mp                em
);
   import rv_pkg::*;

   logic [xlen-1:0] result;
   logic [xlen-1:0] pc_plus4;
   logic            taken;

   assign pc_plus4 = ex_i.pc + 32'd4;

   always_comb begin
      case (ex_i.op)
         op_add:  result = op1_i + op2_i;
         op_sub:  result = op1_i - op2_i;
         op_and:  result = op1_i & op2_i;
         op_or:   result = op1_i | op2_i;
         op_xor:  result = op1_i ^ op2_i;
         op_slt:  result = {{(xlen-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
         op_sll:  result = op1_i << op2_i[4:0];
         op_srl:  result = op1_i >> op2_i[4:0];
         op_addi: result = op1_i + ex_i.imm;
         op_andi: result = op1_i & ex_i.imm;
         op_ori:  result = op1_i | ex_i.imm;
         op_xori: result = op1_i ^ ex_i.imm;
         op_slti: result = {{(xlen-1){1'b0}}, $signed(op1_i) < $signed(ex_i.imm)};
         op_lui:  result = ex_i.imm;
         // effective address for memory ops
         op_lw:   result = op1_i + ex_i.imm;
         op_sw:   result = op1_i + ex_i.imm;
         // link value
         op_jal:  result = pc_plus4;
         op_jalr: result = pc_plus4;
         default: result = '0;
      endcase
   end

   always_comb begin
      case (ex_i.op)
         op_beq:  taken = (op1_i == op2_i);
         op_bne:  taken = (op1_i != op2_i);
         op_blt:  taken = ($signed(op1_i) < $signed(op2_i));
         default: taken = 1'b0;
      endcase
   end

   assign redirect_o = taken || ex_i.op == op_jal || ex_i.op == op_jalr;
   // jalr clears bit 0 of the sum
   assign target_o   = (ex_i.op == op_jalr) ? ((op1_i + ex_i.imm) & ~32'd1)
                                            : (ex_i.pc + ex_i.imm);

   assign em.alu_result = result;
   assign em.store_data = op2_i;
   assign em.rd         = ex_i.rd;
   assign em.reg_write  = ex_i.reg_write;
   assign em.mem_read   = ex_i.mem_read;
   assign em.mem_write  = ex_i.mem_write;

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [4:0]              rs1_i,
   input  logic [4:0]              rs2_i,
   input  logic [4:0]              rd_i,
   input  logic                    we_i,
   input  logic [rv_pkg::xlen-1:0] wd_i,
   output logic [rv_pkg::xlen-1:0] rd1_o,
   output logic [rv_pkg::xlen-1:0] rd2_o
);
   import rv_pkg::*;

   logic [xlen-1:0] regs [32];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we_i && rd_i != 5'd0) begin
         regs[rd_i] <= wd_i;
      end
   end

   // writeback data bypasses the array in the same cycle
   assign rd1_o = (rs1_i == 5'd0) ? '0 :
                  (we_i && rd_i == rs1_i) ? wd_i : regs[rs1_i];
   assign rd2_o = (rs2_i == 5'd0) ? '0 :
                  (we_i && rd_i == rs2_i) ? wd_i : regs[rs2_i];

endmodule

/* source/decoder.sv */
`timescale 1ns/1ps

module decoder (
   input  rv_pkg::insn_u           insn_i,
   output logic [4:0]              rs1_o,
   output logic [4:0]              rs2_o,
   output logic [4:0]              rd_o,
   output logic [rv_pkg::xlen-1:0] imm_o,
   output rv_pkg::op_e             op_o,
   output logic                    reg_write_o,
   output logic                    mem_read_o,
   output logic                    mem_write_o
);
   import rv_pkg::*;

   logic [6:0]      opcode;
   logic [2:0]      funct3;
   logic [6:0]      funct7;
   logic [xlen-1:0] imm_i;
   logic [xlen-1:0] imm_s;
   logic [xlen-1:0] imm_b;
   logic [xlen-1:0] imm_u;
   logic [xlen-1:0] imm_j;

   assign opcode = insn_i.r_fmt.opcode;
   assign funct3 = insn_i.r_fmt.funct3;
   assign funct7 = insn_i.r_fmt.funct7;

   assign imm_i = {{20{insn_i.i_fmt.imm_11_0[11]}}, insn_i.i_fmt.imm_11_0};
   assign imm_s = {{20{insn_i.s_fmt.imm_11_5[6]}}, insn_i.s_fmt.imm_11_5,
                   insn_i.s_fmt.imm_4_0};
   assign imm_b = {{19{insn_i.b_fmt.imm_12}}, insn_i.b_fmt.imm_12, insn_i.b_fmt.imm_11,
                   insn_i.b_fmt.imm_10_5, insn_i.b_fmt.imm_4_1, 1'b0};
   // U and J fields have no view of their own, rebuilt from the R fields
   assign imm_u = {insn_i.r_fmt.funct7, insn_i.r_fmt.rs2, insn_i.r_fmt.rs1,
                   insn_i.r_fmt.funct3, 12'b0};
   assign imm_j = {{12{insn_i.r_fmt.funct7[6]}}, insn_i.r_fmt.rs1, insn_i.r_fmt.funct3,
                   insn_i.r_fmt.rs2[0], insn_i.r_fmt.funct7[5:0], insn_i.r_fmt.rs2[4:1],
                   1'b0};

   always_comb begin
      op_o        = op_nop;
      reg_write_o = 1'b0;
      mem_read_o  = 1'b0;
      mem_write_o = 1'b0;
      rd_o        = insn_i.r_fmt.rd;
      // unused sources stay at x0 so they never cause a stall
      rs1_o       = 5'd0;
      rs2_o       = 5'd0;
      imm_o       = '0;
      case (opcode)
         opc_reg: begin
            rs1_o = insn_i.r_fmt.rs1;
            rs2_o = insn_i.r_fmt.rs2;
            case ({funct7, funct3})
               {7'h00, 3'b000}: op_o = op_add;
               {7'h20, 3'b000}: op_o = op_sub;
               {7'h00, 3'b111}: op_o = op_and;
               {7'h00, 3'b110}: op_o = op_or;
               {7'h00, 3'b100}: op_o = op_xor;
               {7'h00, 3'b010}: op_o = op_slt;
               {7'h00, 3'b001}: op_o = op_sll;
               {7'h00, 3'b101}: op_o = op_srl;
               default:         op_o = op_nop;
            endcase
            reg_write_o = (op_o != op_nop);
         end
         opc_imm: begin
            rs1_o = insn_i.i_fmt.rs1;
            imm_o = imm_i;
            case (funct3)
               3'b000:  op_o = op_addi;
               3'b111:  op_o = op_andi;
               3'b110:  op_o = op_ori;
               3'b100:  op_o = op_xori;
               3'b010:  op_o = op_slti;
               default: op_o = op_nop;
            endcase
            reg_write_o = (op_o != op_nop);
         end
         opc_lui: begin
            op_o        = op_lui;
            imm_o       = imm_u;
            reg_write_o = 1'b1;
         end
         opc_load: begin
            if (funct3 == 3'b010) begin
               op_o        = op_lw;
               rs1_o       = insn_i.i_fmt.rs1;
               imm_o       = imm_i;
               reg_write_o = 1'b1;
               mem_read_o  = 1'b1;
            end
         end
         opc_store: begin
            if (funct3 == 3'b010) begin
               op_o        = op_sw;
               rs1_o       = insn_i.s_fmt.rs1;
               rs2_o       = insn_i.s_fmt.rs2;
               imm_o       = imm_s;
               mem_write_o = 1'b1;
            end
         end
         opc_branch: begin
            rs1_o = insn_i.b_fmt.rs1;
            rs2_o = insn_i.b_fmt.rs2;
            imm_o = imm_b;
            case (funct3)
               3'b000:  op_o = op_beq;
               3'b001:  op_o = op_bne;
               3'b100:  op_o = op_blt;
               default: op_o = op_nop;
            endcase
         end
         opc_jal: begin
            op_o        = op_jal;
            imm_o       = imm_j;
            reg_write_o = 1'b1;
         end
         opc_jalr: begin
            if (funct3 == 3'b000) begin
               op_o        = op_jalr;
               rs1_o       = insn_i.i_fmt.rs1;
               imm_o       = imm_i;
               reg_write_o = 1'b1;
            end
         end
         default: begin
            op_o = op_nop;
         end
      endcase
   end

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       stall_i,
   input  logic                       redirect_i,
   input  logic [rv_pkg::xlen-1:0]    target_i,
   input  logic                       imem_we_i,
   input  logic [rv_pkg::imem_aw-1:0] imem_addr_i,
   input  logic [rv_pkg::xlen-1:0]    imem_data_i,
   output logic [rv_pkg::xlen-1:0]    pc_o,
   output logic [rv_pkg::xlen-1:0]    insn_o
);
   import rv_pkg::*;

   logic [xlen-1:0] imem [imem_words];
   logic [xlen-1:0] pc_q;
   logic [xlen-1:0] insn_q;

   // program load port, only open while the core is held in reset
   always_ff @(posedge clk) begin
      if (reset && imem_we_i) begin
         imem[imem_addr_i] <= imem_data_i;
      end
   end

   // insn_q is the instruction half of the fetch/decode register
   always_ff @(posedge clk) begin
      if (reset) begin
         pc_q   <= '0;
         insn_q <= '0;
      end else if (redirect_i) begin
         pc_q   <= target_i;
         // all-zero word decodes as a bubble
         insn_q <= '0;
      end else if (!stall_i) begin
         pc_q   <= pc_q + 32'd4;
         insn_q <= imem[pc_q[imem_aw+1:2]];
      end
   end

   assign pc_o   = pc_q;
   assign insn_o = insn_q;

endmodule

/* source/exmem_if.sv */
`timescale 1ns/1ps

interface exmem_if;
   import rv_pkg::*;

   logic [xlen-1:0] alu_result;
   logic [xlen-1:0] store_data;
   logic [4:0]      rd;
   logic            reg_write;
   logic            mem_read;
   logic            mem_write;

   // execute side, driven combinationally
   modport exec_mp (output alu_result, store_data, rd, reg_write, mem_read, mem_write);

   // sampled by the execute/memory register
   modport reg_mp (input alu_result, store_data, rd, reg_write, mem_read, mem_write);

   // registered copy seen by the data memory
   modport mem_mp (input alu_result, store_data, mem_read, mem_write);

endinterface

/* source/rv_pkg.sv */
package rv_pkg;

   localparam int xlen       = 32;
   localparam int imem_words = 256;
   localparam int dmem_words = 256;
   localparam int imem_aw    = $clog2(imem_words);
   localparam int dmem_aw    = $clog2(dmem_words);

   // major opcodes of the supported subset
   localparam logic [6:0] opc_reg    = 7'b0110011;
   localparam logic [6:0] opc_imm    = 7'b0010011;
   localparam logic [6:0] opc_lui    = 7'b0110111;
   localparam logic [6:0] opc_load   = 7'b0000011;
   localparam logic [6:0] opc_store  = 7'b0100011;
   localparam logic [6:0] opc_branch = 7'b1100011;
   localparam logic [6:0] opc_jal    = 7'b1101111;
   localparam logic [6:0] opc_jalr   = 7'b1100111;

   // op_nop must stay at zero, a cleared register is a bubble
   typedef enum logic [4:0] {
      op_nop,
      op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sll, op_srl,
      op_addi, op_andi, op_ori, op_xori, op_slti,
      op_lui,
      op_lw, op_sw,
      op_beq, op_bne, op_blt,
      op_jal, op_jalr
   } op_e;

   typedef enum logic [1:0] {
      fwd_none,
      fwd_mem,
      fwd_wb
   } fwd_e;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
   } s_fmt_t;

   typedef struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
   } b_fmt_t;

   // one instruction word seen in each of its formats
   typedef union packed {
      r_fmt_t r_fmt;
      i_fmt_t i_fmt;
      s_fmt_t s_fmt;
      b_fmt_t b_fmt;
   } insn_u;

   typedef struct packed {
      logic [xlen-1:0] pc;
      logic [4:0]      rs1;
      logic [4:0]      rs2;
      logic [4:0]      rd;
      logic [xlen-1:0] op1;
      logic [xlen-1:0] op2;
      logic [xlen-1:0] imm;
      op_e             op;
      logic            reg_write;
      logic            mem_read;
      logic            mem_write;
   } id_ex_t;

   typedef struct packed {
      logic [4:0]      rd;
      logic [xlen-1:0] result;
      logic            reg_write;
   } mem_wb_t;

endpackage
